//--- iq_pkg.sv
// shared widths, enums and structs for the ALU/MDU issue queue; compile before any RTL file
package iq_pkg;

    // ------------------------------
    // widths and counts
    localparam int LOG_PR_COUNT       = 6;
    localparam int LOG_PRF_BANK_COUNT = 2;
    localparam int PRF_BANK_COUNT     = 4;
    localparam int LOG_ROB_ENTRIES    = 6;
    localparam int DISPATCH_WAYS      = 2;

    typedef logic [LOG_PR_COUNT-1:0]                    pr_t;
    typedef logic [LOG_PR_COUNT-LOG_PRF_BANK_COUNT-1:0] upper_pr_t;
    typedef logic [LOG_ROB_ENTRIES-1:0]                 rob_idx_t;

    // ------------------------------
    // enums
    // alu and mdu codes live in one space, passed through untouched
    typedef enum logic [3:0] {
        OP_ADD  = 4'h0,
        OP_SUB  = 4'h1,
        OP_SLL  = 4'h2,
        OP_SLT  = 4'h3,
        OP_SLTU = 4'h4,
        OP_XOR  = 4'h5,
        OP_SRL  = 4'h6,
        OP_SRA  = 4'h7,
        OP_OR   = 4'h8,
        OP_AND  = 4'h9,
        OP_MUL  = 4'hA,
        OP_MULH = 4'hB,
        OP_DIV  = 4'hC,
        OP_DIVU = 4'hD,
        OP_REM  = 4'hE,
        OP_REMU = 4'hF
    } iq_op_e;

    // entry is valid whenever pipe is not none
    typedef enum logic [1:0] {
        PIPE_NONE = 2'd0,
        PIPE_ALU  = 2'd1,
        PIPE_MDU  = 2'd2
    } pipe_e;

    // ------------------------------
    // structs
    typedef struct packed {
        pipe_e    pipe;
        iq_op_e   op;
        pr_t      a_pr;
        logic     a_ready;
        logic     a_is_zero;
        pr_t      b_pr;
        logic     b_ready;
        logic     b_is_zero;
        pr_t      dest_pr;
        rob_idx_t rob_index;
    } iq_entry_t;

    typedef struct packed {
        logic      valid;
        upper_pr_t upper_pr;
    } wb_bank_t;

    // req_valid high means the operand still has to come from the register file
    typedef struct packed {
        logic     valid;
        iq_op_e   op;
        logic     a_forward;
        logic     a_is_zero;
        logic     a_req_valid;
        pr_t      a_pr;
        logic     b_forward;
        logic     b_is_zero;
        logic     b_req_valid;
        pr_t      b_pr;
        pr_t      dest_pr;
        rob_idx_t rob_index;
    } issue_op_t;

endpackage

//--- iq_dispatch.sv
// hands free queue entries to the dispatch ways in way order; combinational, used once in the queue top
module iq_dispatch #(
    parameter int IQ_ENTRIES = 8
) (
    input  logic [IQ_ENTRIES-1:0]                                   occupied,
    input  logic [iq_pkg::DISPATCH_WAYS-1:0]                        dispatch_attempt,
    input  iq_pkg::iq_entry_t [iq_pkg::DISPATCH_WAYS-1:0]           dispatch_op,
    output logic [iq_pkg::DISPATCH_WAYS-1:0]                        dispatch_ack,
    output iq_pkg::iq_entry_t [IQ_ENTRIES-1:0]                      write_by_entry
);

    import iq_pkg::*;

    // one-hot entry won by each way or zero
    logic [DISPATCH_WAYS-1:0][IQ_ENTRIES-1:0] grant_by_way;

    // ------------------------------
    // cascaded lowest-free pickers
    always_comb begin
        logic [IQ_ENTRIES-1:0] open;

        // room is judged on the queue as it stands this cycle
        open = ~occupied;

        for (int w = 0; w < DISPATCH_WAYS; w++) begin
            // lowest set bit of the open mask
            grant_by_way[w] = (open & -open) & {IQ_ENTRIES{dispatch_attempt[w]}};
            dispatch_ack[w] = dispatch_attempt[w] & (|open);

            // next way only sees what is left
            open = open & ~grant_by_way[w];
        end
    end

    // ------------------------------
    // route ways onto their entries
    always_comb begin
        // pipe none everywhere nothing lands
        write_by_entry = '0;

        for (int e = 0; e < IQ_ENTRIES; e++) begin
            for (int w = 0; w < DISPATCH_WAYS; w++) begin
                if (grant_by_way[w][e]) begin
                    write_by_entry[e] = dispatch_op[w];
                end
            end
        end
    end

endmodule

//--- iq_select.sv
// finds the oldest ready entry of one pipe and builds its issue struct; one instance per pipeline
module iq_select #(
    parameter int            IQ_ENTRIES = 8,
    parameter iq_pkg::pipe_e SEL_PIPE   = iq_pkg::PIPE_ALU
) (
    input  iq_pkg::iq_entry_t [IQ_ENTRIES-1:0] entries,
    input  logic [IQ_ENTRIES-1:0]              a_forward,
    input  logic [IQ_ENTRIES-1:0]              b_forward,
    input  logic                               pipe_ready,
    output iq_pkg::issue_op_t                  issue,
    output logic [IQ_ENTRIES-1:0]              issue_mask
);

    import iq_pkg::*;

    logic [IQ_ENTRIES-1:0] ready_vec;
    logic [IQ_ENTRIES-1:0] pick;

    // ------------------------------
    // ready check
    always_comb begin
        for (int i = 0; i < IQ_ENTRIES; i++) begin
            ready_vec[i] = pipe_ready
                & (entries[i].pipe == SEL_PIPE)
                & (entries[i].a_ready | a_forward[i] | entries[i].a_is_zero)
                & (entries[i].b_ready | b_forward[i] | entries[i].b_is_zero);
        end
    end

    // ------------------------------
    // oldest first
    // entry 0 is the oldest, so take the lowest set bit
    assign pick = ready_vec & -ready_vec;

    // chosen entry and everything above it mark where the collapse begins
    assign issue_mask = ready_vec | -ready_vec;

    // ------------------------------
    // one-hot mux into the issue struct
    always_comb begin
        issue       = '0;
        issue.valid = |ready_vec;

        for (int i = 0; i < IQ_ENTRIES; i++) begin
            if (pick[i]) begin
                issue.op          = entries[i].op;

                issue.a_forward   = a_forward[i];
                issue.a_is_zero   = entries[i].a_is_zero;
                // forwarded or zero operands need no register read
                issue.a_req_valid = ~a_forward[i] & ~entries[i].a_is_zero;
                issue.a_pr        = entries[i].a_pr;

                issue.b_forward   = b_forward[i];
                issue.b_is_zero   = entries[i].b_is_zero;
                issue.b_req_valid = ~b_forward[i] & ~entries[i].b_is_zero;
                issue.b_pr        = entries[i].b_pr;

                issue.dest_pr     = entries[i].dest_pr;
                issue.rob_index   = entries[i].rob_index;
            end
        end
    end

endmodule

//--- iq_entries.sv
// holds the queued ops, wakes their sources on writeback and collapses issued slots; used once
module iq_entries #(
    parameter int IQ_ENTRIES = 8
) (
    input  logic                                        CLK,
    input  logic                                        nRST,
    input  iq_pkg::iq_entry_t [IQ_ENTRIES-1:0]          write_by_entry,
    input  iq_pkg::wb_bank_t [iq_pkg::PRF_BANK_COUNT-1:0] wb_bus,
    input  logic [IQ_ENTRIES-1:0]                       alu_issue_mask,
    input  logic [IQ_ENTRIES-1:0]                       mdu_issue_mask,
    output iq_pkg::iq_entry_t [IQ_ENTRIES-1:0]          entries,
    output logic [IQ_ENTRIES-1:0]                       occupied,
    output logic [IQ_ENTRIES-1:0]                       a_forward,
    output logic [IQ_ENTRIES-1:0]                       b_forward
);

    import iq_pkg::*;

    // masks padded one place up so the top entry needs no special case
    logic [IQ_ENTRIES:0] alu_cover;
    logic [IQ_ENTRIES:0] mdu_cover;

    iq_entry_t [IQ_ENTRIES-1:0] woken_entries;
    iq_entry_t [IQ_ENTRIES-1:0] woken_writes;
    iq_entry_t [IQ_ENTRIES-1:0] next_entries;

    // bank picked by the low tag bits, then compare the rest
    function automatic logic wb_match(
        input pr_t                               pr,
        input wb_bank_t [PRF_BANK_COUNT-1:0]     bus
    );
        wb_bank_t bank;

        bank = bus[pr[LOG_PRF_BANK_COUNT-1:0]];
        return bank.valid && (bank.upper_pr == pr[LOG_PR_COUNT-1:LOG_PRF_BANK_COUNT]);
    endfunction

    // op with its ready bits updated by this cycle's writebacks
    function automatic iq_entry_t wake(
        input iq_entry_t                         e,
        input wb_bank_t [PRF_BANK_COUNT-1:0]     bus
    );
        iq_entry_t w;

        w         = e;
        w.a_ready = e.a_ready | wb_match(e.a_pr, bus);
        w.b_ready = e.b_ready | wb_match(e.b_pr, bus);
        return w;
    endfunction

    // ------------------------------
    // wakeup
    always_comb begin
        for (int i = 0; i < IQ_ENTRIES; i++) begin
            occupied[i]      = entries[i].pipe != PIPE_NONE;
            a_forward[i]     = wb_match(entries[i].a_pr, wb_bus);
            b_forward[i]     = wb_match(entries[i].b_pr, wb_bus);
            woken_entries[i] = wake(entries[i], wb_bus);
            // a writeback during dispatch must not be lost either
            woken_writes[i]  = wake(write_by_entry[i], wb_bus);
        end
    end

    // ------------------------------
    // collapse towards entry 0
    assign alu_cover = {alu_issue_mask[IQ_ENTRIES-1], alu_issue_mask};
    assign mdu_cover = {mdu_issue_mask[IQ_ENTRIES-1], mdu_issue_mask};

    always_comb begin
        int unsigned src;
        logic        two_up;
        logic        one_up;

        for (int i = 0; i < IQ_ENTRIES; i++) begin
            // both issues at or below i+1 means skip two places
            two_up = (alu_cover[i] & mdu_cover[i+1]) | (mdu_cover[i] & alu_cover[i+1]);
            one_up = alu_cover[i] | mdu_cover[i];

            if (two_up) begin
                src = i + 2;
            end else if (one_up) begin
                src = i + 1;
            end else begin
                src = i;
            end

            if (src >= IQ_ENTRIES) begin
                // nothing above the top so the slot empties
                next_entries[i] = '0;
            end else if (entries[src].pipe != PIPE_NONE) begin
                next_entries[i] = woken_entries[src];
            end else begin
                // source slot is empty so take whatever dispatch put there
                next_entries[i] = woken_writes[src];
            end
        end
    end

    // ------------------------------
    // entry registers
    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            for (int i = 0; i < IQ_ENTRIES; i++) begin
                entries[i].pipe <= PIPE_NONE;
            end
        end else begin
            entries <= next_entries;
        end
    end

endmodule

//--- alu_reg_mdu_iq.sv
// top level of the ALU/MDU issue queue that ties dispatch, entry storage and both selects together
module alu_reg_mdu_iq #(
    parameter int IQ_ENTRIES = 8
) (
    input  logic                                            CLK,
    input  logic                                            nRST,
    input  logic [iq_pkg::DISPATCH_WAYS-1:0]                dispatch_attempt,
    input  iq_pkg::iq_entry_t [iq_pkg::DISPATCH_WAYS-1:0]   dispatch_op,
    output logic [iq_pkg::DISPATCH_WAYS-1:0]                dispatch_ack,
    input  iq_pkg::wb_bank_t [iq_pkg::PRF_BANK_COUNT-1:0]   wb_bus,
    input  logic                                            alu_ready,
    input  logic                                            mdu_ready,
    output iq_pkg::issue_op_t                               issue_alu,
    output iq_pkg::issue_op_t                               issue_mdu
);

    import iq_pkg::*;

    logic [IQ_ENTRIES-1:0]      occupied;
    iq_entry_t [IQ_ENTRIES-1:0] write_by_entry;
    iq_entry_t [IQ_ENTRIES-1:0] entries;
    logic [IQ_ENTRIES-1:0]      a_forward;
    logic [IQ_ENTRIES-1:0]      b_forward;
    logic [IQ_ENTRIES-1:0]      alu_issue_mask;
    logic [IQ_ENTRIES-1:0]      mdu_issue_mask;

    // ------------------------------
    // dispatch and storage
    iq_dispatch #(.IQ_ENTRIES(IQ_ENTRIES)) i_dispatch (
        .occupied         (occupied),
        .dispatch_attempt (dispatch_attempt),
        .dispatch_op      (dispatch_op),
        .dispatch_ack     (dispatch_ack),
        .write_by_entry   (write_by_entry)
    );

    iq_entries #(.IQ_ENTRIES(IQ_ENTRIES)) i_entries (
        .CLK            (CLK),
        .nRST           (nRST),
        .write_by_entry (write_by_entry),
        .wb_bus         (wb_bus),
        .alu_issue_mask (alu_issue_mask),
        .mdu_issue_mask (mdu_issue_mask),
        .entries        (entries),
        .occupied       (occupied),
        .a_forward      (a_forward),
        .b_forward      (b_forward)
    );

    // ------------------------------
    // one select per pipeline
    iq_select #(.IQ_ENTRIES(IQ_ENTRIES), .SEL_PIPE(PIPE_ALU)) i_sel_alu (
        .entries    (entries),
        .a_forward  (a_forward),
        .b_forward  (b_forward),
        .pipe_ready (alu_ready),
        .issue      (issue_alu),
        .issue_mask (alu_issue_mask)
    );

    iq_select #(.IQ_ENTRIES(IQ_ENTRIES), .SEL_PIPE(PIPE_MDU)) i_sel_mdu (
        .entries    (entries),
        .a_forward  (a_forward),
        .b_forward  (b_forward),
        .pipe_ready (mdu_ready),
        .issue      (issue_mdu),
        .issue_mask (mdu_issue_mask)
    );

endmodule

//--- tb_alu_reg_mdu_iq.sv
// self-checking testbench for the ALU/MDU issue queue that steps through a table of per-cycle rows
module tb_alu_reg_mdu_iq;
    timeunit 1ns;
    timeprecision 100ps;

    import iq_pkg::*;

    localparam int PERIOD       = 8;
    localparam int RESET_CYCLES = 2;
    localparam int NUM_ROWS     = 27;

    // source state as {is_zero, ready}
    localparam logic [1:0] S_WAIT = 2'b00;
    localparam logic [1:0] S_RDY  = 2'b01;
    localparam logic [1:0] S_ZERO = 2'b10;

    // one clock cycle of stimulus and the answer expected in that cycle
    typedef struct packed {
        logic [1:0]                    att;
        iq_entry_t                     op0;
        iq_entry_t                     op1;
        logic [1:0]                    rdy;      // {alu, mdu}
        wb_bank_t [PRF_BANK_COUNT-1:0] wb;
        logic [1:0]                    ack;
        logic                          alu_v;
        rob_idx_t                      alu_rob;
        logic [2:0]                    alu_src;  // {a_req_valid, b_req_valid, b_forward}
        logic                          mdu_v;
        rob_idx_t                      mdu_rob;
    } row_t;

    logic                          CLK = 1'b0;
    logic                          nRST;
    logic [DISPATCH_WAYS-1:0]      dispatch_attempt;
    iq_entry_t [DISPATCH_WAYS-1:0] dispatch_op;
    logic [DISPATCH_WAYS-1:0]      dispatch_ack;
    wb_bank_t [PRF_BANK_COUNT-1:0] wb_bus;
    logic                          alu_ready;
    logic                          mdu_ready;
    issue_op_t                     issue_alu;
    issue_op_t                     issue_mdu;

    row_t rows [NUM_ROWS];
    int   n_rows   = 0;
    int   n_checks = 0;
    int   n_errors = 0;

    alu_reg_mdu_iq #(.IQ_ENTRIES(4)) i_dut (
        .CLK              (CLK),
        .nRST             (nRST),
        .dispatch_attempt (dispatch_attempt),
        .dispatch_op      (dispatch_op),
        .dispatch_ack     (dispatch_ack),
        .wb_bus           (wb_bus),
        .alu_ready        (alu_ready),
        .mdu_ready        (mdu_ready),
        .issue_alu        (issue_alu),
        .issue_mdu        (issue_mdu)
    );

    always #(PERIOD / 2) CLK = ~CLK;

    // ------------------------------
    // op and bus builders
    function automatic pr_t dest_of(input rob_idx_t rob);
        return pr_t'(rob) + pr_t'(32);
    endfunction

    function automatic iq_entry_t mk_op(input pipe_e pipe, input rob_idx_t rob,
                                        input pr_t a_pr, input logic [1:0] a_st,
                                        input pr_t b_pr, input logic [1:0] b_st);
        iq_entry_t e;

        e           = '0;
        e.pipe      = pipe;
        e.op        = (pipe == PIPE_MDU) ? OP_MUL : OP_SUB;
        e.a_pr      = a_pr;
        e.a_ready   = a_st[0];
        e.a_is_zero = a_st[1];
        e.b_pr      = b_pr;
        e.b_ready   = b_st[0];
        e.b_is_zero = b_st[1];
        e.dest_pr   = dest_of(rob);
        e.rob_index = rob;
        return e;
    endfunction

    function automatic iq_entry_t ready_op(input pipe_e pipe, input rob_idx_t rob);
        return mk_op(pipe, rob, 6'd1, S_RDY, 6'd2, S_RDY);
    endfunction

    // source A ready and source B waiting on a tag
    function automatic iq_entry_t wait_b(input pipe_e pipe, input rob_idx_t rob, input pr_t b_pr);
        return mk_op(pipe, rob, 6'd1, S_RDY, b_pr, S_WAIT);
    endfunction

    // low tag bits pick the bank and the rest goes on the bus
    function automatic logic [PRF_BANK_COUNT*5-1:0] wb_hit(input pr_t pr);
        wb_bank_t [PRF_BANK_COUNT-1:0] bus;

        bus = '0;
        bus[pr[1:0]].valid    = 1'b1;
        bus[pr[1:0]].upper_pr = pr[5:2];
        return bus;
    endfunction

    task automatic add_row(input logic [1:0] att, input iq_entry_t op0, input iq_entry_t op1,
                           input logic [1:0] rdy, input logic [PRF_BANK_COUNT*5-1:0] wb,
                           input logic [1:0] ack, input logic alu_v, input rob_idx_t alu_rob,
                           input logic [2:0] alu_src, input logic mdu_v,
                           input rob_idx_t mdu_rob);
        if (n_rows < NUM_ROWS) begin
            rows[n_rows] = {att, op0, op1, rdy, wb, ack, alu_v, alu_rob, alu_src, mdu_v, mdu_rob};
        end
        n_rows++;
    endtask

    task automatic check_value(input int row, input string what,
                               input logic [31:0] got, input logic [31:0] expected);
        n_checks++;
        if (got !== expected) begin
            n_errors++;
            $display("mismatch at %0d ns: row %0d %s is %0h, expected %0h",
                     $time, row, what, got, expected);
        end
    endtask

    // ------------------------------
    // stimulus table
    task automatic fill_table();
        // nothing to issue right after reset, then one ready alu op
        add_row(2'b00, '0, '0, 2'b11, '0, 2'b00, 0, 0, 3'b000, 0, 0);
        add_row(2'b01, ready_op(PIPE_ALU, 1), '0, 2'b11, '0, 2'b01, 0, 0, 3'b000, 0, 0);
        add_row(2'b00, '0, '0, 2'b11, '0, 2'b00, 1, 1, 3'b110, 0, 0);
        // three alu ops and one mdu op all waiting on tag 12
        add_row(2'b11, wait_b(PIPE_ALU, 2, 12), wait_b(PIPE_ALU, 3, 12), 2'b11, '0,
                2'b11, 0, 0, 3'b000, 0, 0);
        add_row(2'b11, wait_b(PIPE_MDU, 4, 12), wait_b(PIPE_ALU, 5, 12), 2'b11, '0,
                2'b11, 0, 0, 3'b000, 0, 0);
        add_row(2'b00, '0, '0, 2'b11, wb_hit(12), 2'b00, 1, 2, 3'b101, 1, 4);
        add_row(2'b00, '0, '0, 2'b11, '0, 2'b00, 1, 3, 3'b110, 0, 0);
        add_row(2'b00, '0, '0, 2'b11, '0, 2'b00, 1, 5, 3'b110, 0, 0);
        // wakeup on tag 22 where tag 26 shares the bank but must not match
        add_row(2'b01, mk_op(PIPE_ALU, 6, 6'd0, S_ZERO, 6'd22, S_WAIT), '0, 2'b11, '0,
                2'b01, 0, 0, 3'b000, 0, 0);
        add_row(2'b00, '0, '0, 2'b11, wb_hit(26), 2'b00, 0, 0, 3'b000, 0, 0);
        add_row(2'b00, '0, '0, 2'b11, wb_hit(22), 2'b00, 1, 6, 3'b001, 0, 0);
        add_row(2'b01, mk_op(PIPE_ALU, 7, 6'd1, S_RDY, 6'd0, S_ZERO), '0, 2'b11, '0,
                2'b01, 0, 0, 3'b000, 0, 0);
        add_row(2'b00, '0, '0, 2'b11, '0, 2'b00, 1, 7, 3'b100, 0, 0);
        // mdu held off while alu keeps going
        add_row(2'b11, ready_op(PIPE_MDU, 8), ready_op(PIPE_MDU, 9), 2'b10, '0,
                2'b11, 0, 0, 3'b000, 0, 0);
        add_row(2'b01, ready_op(PIPE_ALU, 10), '0, 2'b10, '0, 2'b01, 0, 0, 3'b000, 0, 0);
        add_row(2'b00, '0, '0, 2'b10, '0, 2'b00, 1, 10, 3'b110, 0, 0);
        add_row(2'b00, '0, '0, 2'b11, '0, 2'b00, 0, 0, 3'b000, 1, 8);
        add_row(2'b00, '0, '0, 2'b11, '0, 2'b00, 0, 0, 3'b000, 1, 9);
        // fill all four entries, then retry against a full queue
        add_row(2'b11, ready_op(PIPE_ALU, 11), ready_op(PIPE_ALU, 12), 2'b00, '0,
                2'b11, 0, 0, 3'b000, 0, 0);
        add_row(2'b11, ready_op(PIPE_ALU, 13), ready_op(PIPE_MDU, 14), 2'b00, '0,
                2'b11, 0, 0, 3'b000, 0, 0);
        add_row(2'b11, ready_op(PIPE_ALU, 15), ready_op(PIPE_ALU, 16), 2'b00, '0,
                2'b00, 0, 0, 3'b000, 0, 0);
        add_row(2'b11, ready_op(PIPE_ALU, 15), ready_op(PIPE_ALU, 16), 2'b10, '0,
                2'b00, 1, 11, 3'b110, 0, 0);
        add_row(2'b11, ready_op(PIPE_ALU, 15), ready_op(PIPE_ALU, 16), 2'b00, '0,
                2'b01, 0, 0, 3'b000, 0, 0);
        add_row(2'b01, ready_op(PIPE_ALU, 16), '0, 2'b11, '0, 2'b00, 1, 12, 3'b110, 1, 14);
        add_row(2'b01, ready_op(PIPE_ALU, 16), '0, 2'b11, '0, 2'b01, 1, 13, 3'b110, 0, 0);
        add_row(2'b00, '0, '0, 2'b11, '0, 2'b00, 1, 15, 3'b110, 0, 0);
        add_row(2'b00, '0, '0, 2'b11, '0, 2'b00, 1, 16, 3'b110, 0, 0);
    endtask

    // ------------------------------
    // reset, then one row per clock
    initial begin
        row_t row;

        nRST             = 1'b0;
        dispatch_attempt = '0;
        dispatch_op      = '0;
        wb_bus           = '0;
        alu_ready        = 1'b0;
        mdu_ready        = 1'b0;

        fill_table();
        if (n_rows != NUM_ROWS) begin
            $display("stimulus table holds %0d rows instead of %0d", n_rows, NUM_ROWS);
            n_errors++;
        end

        repeat (RESET_CYCLES) @(posedge CLK);
        nRST <= 1'b1;

        for (int r = 0; r < NUM_ROWS; r++) begin
            row = rows[r];
            @(posedge CLK);
            dispatch_attempt <= row.att;
            dispatch_op      <= {row.op1, row.op0};
            alu_ready        <= row.rdy[1];
            mdu_ready        <= row.rdy[0];
            wb_bus           <= row.wb;

            // outputs have settled by the falling edge
            @(negedge CLK);
            check_value(r, "dispatch_ack", dispatch_ack, row.ack);
            check_value(r, "alu valid", issue_alu.valid, row.alu_v);
            if (row.alu_v) begin
                check_value(r, "alu rob_index", issue_alu.rob_index, row.alu_rob);
                check_value(r, "alu dest_pr", issue_alu.dest_pr, dest_of(row.alu_rob));
                check_value(r, "alu op", issue_alu.op, OP_SUB);
                check_value(r, "alu req/forward",
                            {issue_alu.a_req_valid, issue_alu.b_req_valid, issue_alu.b_forward},
                            row.alu_src);
            end
            check_value(r, "mdu valid", issue_mdu.valid, row.mdu_v);
            if (row.mdu_v) begin
                check_value(r, "mdu rob_index", issue_mdu.rob_index, row.mdu_rob);
                check_value(r, "mdu dest_pr", issue_mdu.dest_pr, dest_of(row.mdu_rob));
                check_value(r, "mdu op", issue_mdu.op, OP_MUL);
            end
        end

        $display("checks: %0d  errors: %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

    // watchdog sized from the table length plus reset and some slack
    initial begin
        #((NUM_ROWS + RESET_CYCLES + 10) * PERIOD);
        $display("timeout: the table did not finish within %0d cycles",
                 NUM_ROWS + RESET_CYCLES + 10);
        $display("Something failed");
        $finish;
    end

endmodule

//--- tb.f
iq_pkg.sv
iq_dispatch.sv
iq_select.sv
iq_entries.sv
alu_reg_mdu_iq.sv
tb_alu_reg_mdu_iq.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        := tb_alu_reg_mdu_iq
FILELIST   := tb.f
OBJ_DIR    := obj_dir
LINT_FLAGS := --lint-only --timing -Wno-fatal
SIM_FLAGS  := --binary --timing -Wno-fatal -Mdir $(OBJ_DIR)
PASS_MSG   := Everything OK

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

# the run passes only if the pass message shows up in the output
sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
